// File: verilog.f
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_config_regs.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_top.sv
sim/uart_tb_chk.sv
sim/uart_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the UART testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert -Wno-fatal --top-module uart_tb -f verilog.f \
    -o uart_tb_sim > build.log 2>&1 \
    && ./obj_dir/uart_tb_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; tail -n 40 build.log sim.log 2>/dev/null; exit 1; }

grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; tail -n 40 sim.log; exit 1; }

// File: sim/uart_tb.sv
module uart_tb;

    import uart_pkg::*;

    localparam int DIVISOR_WIDTH  = 16;
    localparam int TIMEOUT_CLOCKS = 2000;

    logic       i_clock;
    logic       i_reset;
    logic       i_cfg_valid;
    uart_cfg_t  i_cfg;
    logic       i_tx_valid;
    uart_byte_t i_tx_data;
    logic       i_rx_ready;
    logic       i_rx;
    logic       o_cfg_ready;
    logic       o_tx_ready;
    logic       o_tx;
    logic       o_rx_valid;
    rx_status_t o_rx_status;

    // Line mux between loopback and bit-banged frames.
    logic loopback;
    logic bang_line;
    assign i_rx = loopback ? o_tx : bang_line;

    rx_status_t  expect_q[$];
    int          received_count = 0;
    logic [31:0] rng_state;
    int          cur_divisor;
    int          cur_stops;
    int          clocks;
    int          sent;
    uart_byte_t  data;

    uart_top #(
        .DIVISOR_WIDTH(DIVISOR_WIDTH)
    ) uut (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_cfg_valid(i_cfg_valid),
        .i_cfg      (i_cfg),
        .i_tx_valid (i_tx_valid),
        .i_tx_data  (i_tx_data),
        .i_rx_ready (i_rx_ready),
        .i_rx       (i_rx),
        .o_cfg_ready(o_cfg_ready),
        .o_tx_ready (o_tx_ready),
        .o_tx       (o_tx),
        .o_rx_valid (o_rx_valid),
        .o_rx_status(o_rx_status)
    );

    always #20 i_clock = ~i_clock;

    //////////////////////////////
    // Reporting
    //////////////////////////////

    task automatic stop_with_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic fail_because(input string why);
        $display("ERROR at time %0t: %s", $time, why);
        stop_with_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    //////////////////////////////
    // Stimulus and reference
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic uart_byte_t next_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    // Status held by the receiver for a byte.
    function automatic rx_status_t expected_status(input uart_byte_t value,
                                                   input logic stop_high,
                                                   input logic prior_unread);
        rx_status_t status;
        status.data        = value;
        status.frame_error = !stop_high;
        status.overrun     = prior_unread;
        return status;
    endfunction

    task automatic write_config(input int divisor, input stop_bits_t stop_bits);
        int guard;
        guard = 0;
        @(negedge i_clock);
        while (!o_cfg_ready) begin
            @(negedge i_clock);
            guard = guard + 1;
            if (guard > TIMEOUT_CLOCKS) fail_because("o_cfg_ready stayed low before a write");
        end
        i_cfg_valid     = 1'b1;
        i_cfg.divisor   = divisor_t'(divisor);
        i_cfg.stop_bits = stop_bits;
        @(negedge i_clock);
        i_cfg_valid = 1'b0;
        cur_divisor = divisor;
        cur_stops   = (stop_bits == STOP_TWO) ? 2 : 1;
    endtask

    task automatic start_tx(input uart_byte_t value);
        int guard;
        guard = 0;
        @(negedge i_clock);
        while (!o_tx_ready) begin
            @(negedge i_clock);
            guard = guard + 1;
            if (guard > TIMEOUT_CLOCKS) fail_because("o_tx_ready stayed low before a send");
        end
        i_tx_valid = 1'b1;
        i_tx_data  = value;
        @(negedge i_clock);
        i_tx_valid = 1'b0;
    endtask

    // Clocks from the acceptance edge to the return of o_tx_ready.
    task automatic finish_tx(output int count);
        count = 0;
        while (!o_tx_ready) begin
            @(negedge i_clock);
            count = count + 1;
            if (count > TIMEOUT_CLOCKS) fail_because("transmit frame never ended");
        end
    endtask

    task automatic check_frame_time(input int count);
        int low;
        low = 16 * (9 + cur_stops) * (cur_divisor + 1);
        if (count < low || count > low + cur_divisor + 1) begin
            fail_because($sformatf("frame took %0d clocks, expected %0d to %0d",
                                   count, low, low + cur_divisor + 1));
        end
    endtask

    task automatic wait_received(input int target);
        int guard;
        guard = 0;
        while (received_count < target) begin
            @(negedge i_clock);
            guard = guard + 1;
            if (guard > TIMEOUT_CLOCKS) fail_because("a byte was never received");
        end
    endtask

    // Start bit and data LSB first, then the stop bit and one high bit.
    task automatic bang_frame(input uart_byte_t value, input logic stop_high);
        logic [10:0] bits;
        bits = {1'b1, stop_high, value, 1'b0};
        for (int i = 0; i < 11; i++) begin
            bang_line = bits[i];
            repeat (16 * (cur_divisor + 1)) @(negedge i_clock);
        end
    endtask

    //////////////////////////////
    // Compare process
    //////////////////////////////

    always @(posedge i_clock) begin
        rx_status_t want;
        if (i_reset && o_rx_valid && i_rx_ready) begin
            if (expect_q.size() == 0) begin
                fail_because("o_rx_valid accepted with no byte expected");
            end else begin
                want = expect_q.pop_front();
                check_value("o_rx_status", {22'd0, o_rx_status}, {22'd0, want});
                received_count = received_count + 1;
            end
        end
    end

    initial begin
        i_clock     = 1'b0;
        i_reset     = 1'b0;
        i_cfg_valid = 1'b0;
        i_cfg       = '0;
        i_tx_valid  = 1'b0;
        i_tx_data   = '0;
        i_rx_ready  = 1'b1;
        loopback    = 1'b0;
        bang_line   = 1'b1;
        rng_state   = 32'h3c69;
        cur_divisor = 3;
        cur_stops   = 1;
        sent        = 0;
        repeat (4) @(negedge i_clock);
        i_reset = 1'b1;
        @(negedge i_clock);
        // Idle state after reset.
        check_value("o_tx", o_tx, 1);
        check_value("o_tx_ready", o_tx_ready, 1);
        check_value("o_cfg_ready", o_cfg_ready, 1);
        check_value("o_rx_valid", o_rx_valid, 0);
        loopback = 1'b1;

        // Loopback at the default rate.
        for (int n = 0; n < 20; n++) begin
            data = next_byte();
            expect_q.push_back(expected_status(data, 1'b1, 1'b0));
            start_tx(data);
            finish_tx(clocks);
            sent = sent + 1;
            wait_received(sent);
        end

        // Divisor 1 with two stop bits.
        write_config(1, STOP_TWO);
        for (int n = 0; n < 6; n++) begin
            data = next_byte();
            expect_q.push_back(expected_status(data, 1'b1, 1'b0));
            start_tx(data);
            finish_tx(clocks);
            check_frame_time(clocks);
            sent = sent + 1;
            wait_received(sent);
        end

        // Bit-banged frame with a low stop bit.
        loopback = 1'b0;
        data = next_byte();
        expect_q.push_back(expected_status(data, 1'b0, 1'b0));
        bang_frame(data, 1'b0);
        sent = sent + 1;
        wait_received(sent);
        loopback = 1'b1;

        // Second frame arrives while the first is unread.
        @(negedge i_clock);
        i_rx_ready = 1'b0;
        data = next_byte();
        start_tx(data);
        finish_tx(clocks);
        start_tx(~data);
        finish_tx(clocks);
        check_value("o_rx_valid", o_rx_valid, 1);
        expect_q.push_back(expected_status(data, 1'b1, 1'b1));
        i_rx_ready = 1'b1;
        sent = sent + 1;
        wait_received(sent);
        repeat (2) @(negedge i_clock);
        check_value("o_rx_valid", o_rx_valid, 0);

        // Config write held off by a transmit.
        data = next_byte();
        expect_q.push_back(expected_status(data, 1'b1, 1'b0));
        start_tx(data);
        i_cfg_valid     = 1'b1;
        i_cfg.divisor   = divisor_t'(3);
        i_cfg.stop_bits = STOP_ONE;
        clocks = 0;
        while (!o_tx_ready || !o_cfg_ready) begin
            if (!o_tx_ready) check_value("o_cfg_ready", o_cfg_ready, 0);
            @(negedge i_clock);
            clocks = clocks + 1;
            if (clocks > TIMEOUT_CLOCKS) fail_because("o_cfg_ready never returned");
        end
        @(negedge i_clock);
        i_cfg_valid = 1'b0;
        cur_divisor = 3;
        cur_stops   = 1;
        sent = sent + 1;
        wait_received(sent);

        // New settings in effect.
        data = next_byte();
        expect_q.push_back(expected_status(data, 1'b1, 1'b0));
        start_tx(data);
        finish_tx(clocks);
        check_frame_time(clocks);
        sent = sent + 1;
        wait_received(sent);

        if (expect_q.size() != 0) begin
            fail_because("expected bytes were never received");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: sim/uart_tb_chk.sv
module uart_tb_chk (
    input logic i_clock,
    input logic i_reset,
    input logic o_tx,
    input logic o_tx_ready,
    input logic o_cfg_ready,
    input logic o_rx_valid,
    input logic i_rx_ready
);

    // Idle transmitter holds the line high.
    tx_idle_high: assert property (
        @(posedge i_clock) disable iff (!i_reset) o_tx_ready |-> o_tx
    ) else $error("o_tx low while o_tx_ready is high");

    // A received byte waits for the consumer.
    rx_valid_held: assert property (
        @(posedge i_clock) disable iff (!i_reset) o_rx_valid && !i_rx_ready |=> o_rx_valid
    ) else $error("o_rx_valid dropped before it was accepted");

    // No config write while a low bit of a frame is on the line.
    cfg_blocked: assert property (
        @(posedge i_clock) disable iff (!i_reset) !o_tx |-> !o_cfg_ready
    ) else $error("o_cfg_ready high while a frame is on the line");

endmodule

bind uart_top uart_tb_chk chk (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .o_tx       (o_tx),
    .o_tx_ready (o_tx_ready),
    .o_cfg_ready(o_cfg_ready),
    .o_rx_valid (o_rx_valid),
    .i_rx_ready (i_rx_ready)
);

// File: hw/uart_top.sv
module uart_top #(
    parameter int DIVISOR_WIDTH = 16
) (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_cfg_valid,
    input  uart_pkg::uart_cfg_t  i_cfg,
    input  logic                 i_tx_valid,
    input  uart_pkg::uart_byte_t i_tx_data,
    input  logic                 i_rx_ready,
    input  logic                 i_rx,
    output logic                 o_cfg_ready,
    output logic                 o_tx_ready,
    output logic                 o_tx,
    output logic                 o_rx_valid,
    output uart_pkg::rx_status_t o_rx_status
);

    import uart_pkg::*;

    uart_cfg_t cfg;
    logic      baud_tick;
    logic      tx_busy;
    logic      rx_busy;

    uart_config_regs #(
        .DIVISOR_WIDTH(DIVISOR_WIDTH)
    ) u_config_regs (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_cfg_valid(i_cfg_valid),
        .i_cfg      (i_cfg),
        .i_tx_busy  (tx_busy),
        .i_rx_busy  (rx_busy),
        .o_cfg_ready(o_cfg_ready),
        .o_cfg      (cfg)
    );

    // Divider uses only the low bits of the divisor field.
    uart_baud_gen #(
        .DIVISOR_WIDTH(DIVISOR_WIDTH)
    ) u_baud_gen (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_divisor(cfg.divisor[DIVISOR_WIDTH-1:0]),
        .o_tick   (baud_tick)
    );

    uart_tx u_tx (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_tick     (baud_tick),
        .i_stop_bits(cfg.stop_bits),
        .i_valid    (i_tx_valid),
        .i_data     (i_tx_data),
        .o_ready    (o_tx_ready),
        .o_busy     (tx_busy),
        .o_tx       (o_tx)
    );

    uart_rx u_rx (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_tick     (baud_tick),
        .i_stop_bits(cfg.stop_bits),
        .i_rx       (i_rx),
        .i_ready    (i_rx_ready),
        .o_valid    (o_rx_valid),
        .o_status   (o_rx_status),
        .o_busy     (rx_busy)
    );

endmodule

// File: hw/uart_rx.sv
module uart_rx (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_tick,
    input  uart_pkg::stop_bits_t i_stop_bits,
    input  logic                 i_rx,
    input  logic                 i_ready,
    output logic                 o_valid,
    output uart_pkg::rx_status_t o_status,
    output logic                 o_busy
);

    import uart_pkg::*;

    rx_state_t   state;
    logic        rx_meta;
    logic        rx_sync;
    logic        rx_prev;
    logic        second_stop;
    tick_count_t tick_cnt;
    bit_index_t  bit_idx;
    uart_byte_t  data_q;
    logic        valid_q;
    rx_status_t  status_q;
    logic        fall;
    logic        mid_start;
    logic        bit_end;
    logic        frame_done;

    assign fall      = rx_prev && !rx_sync;
    assign mid_start = i_tick && (tick_cnt == 4'd7);
    assign bit_end   = i_tick && (tick_cnt == 4'd15);

    // Middle of the first stop bit.
    assign frame_done = (state == RX_STOP) && bit_end && !second_stop;

    assign o_busy   = (state != RX_IDLE);
    assign o_valid  = valid_q;
    assign o_status = status_q;

    // Two-flop synchronizer plus edge history.
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state       <= RX_IDLE;
            second_stop <= 1'b0;
            tick_cnt    <= '0;
            bit_idx     <= '0;
        end else begin
            if (i_tick) begin
                tick_cnt <= tick_cnt + 4'd1;
            end
            case (state)
                RX_IDLE: begin
                    if (fall) begin
                        state    <= RX_START;
                        tick_cnt <= '0;
                    end
                end
                RX_START: begin
                    // A high line here was a glitch.
                    if (mid_start) begin
                        state    <= rx_sync ? RX_IDLE : RX_DATA;
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        data_q[bit_idx] <= rx_sync;
                        if (bit_idx == 3'd7) begin
                            state       <= RX_STOP;
                            second_stop <= 1'b0;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                end
                RX_STOP: begin
                    // Second stop bit is waited out, not checked.
                    if (frame_done && i_stop_bits == STOP_TWO) begin
                        second_stop <= 1'b1;
                    end else if (bit_end) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////
    // Holding register
    //////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            valid_q <= 1'b0;
        end else if (frame_done) begin
            valid_q <= 1'b1;
        end else if (valid_q && i_ready) begin
            valid_q <= 1'b0;
        end
    end

    // An unread byte stays, and only gets its overrun bit.
    always_ff @(posedge i_clock) begin
        if (frame_done) begin
            if (valid_q && !i_ready) begin
                status_q.overrun <= 1'b1;
            end else begin
                status_q.data        <= data_q;
                status_q.frame_error <= !rx_sync;
                status_q.overrun     <= 1'b0;
            end
        end
    end

endmodule

// File: hw/uart_tx.sv
module uart_tx (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_tick,
    input  uart_pkg::stop_bits_t i_stop_bits,
    input  logic                 i_valid,
    input  uart_pkg::uart_byte_t i_data,
    output logic                 o_ready,
    output logic                 o_busy,
    output logic                 o_tx
);

    import uart_pkg::*;

    tx_state_t   state;
    logic        pending;
    logic        second_stop;
    tick_count_t tick_cnt;
    bit_index_t  bit_idx;
    uart_byte_t  data_q;
    logic        tx_q;
    logic        accept;
    logic        bit_end;

    assign o_ready = (state == TX_IDLE) && !pending;
    assign o_busy  = !o_ready;
    assign o_tx    = tx_q;
    assign accept  = o_ready && i_valid;

    // Last tick of the current bit period.
    assign bit_end = i_tick && (tick_cnt == 4'd15);

    // Byte held for the whole frame.
    always_ff @(posedge i_clock) begin
        if (accept) begin
            data_q <= i_data;
        end
    end

    //////////////////////////////
    // Frame FSM
    //////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state       <= TX_IDLE;
            pending     <= 1'b0;
            second_stop <= 1'b0;
            tick_cnt    <= '0;
            bit_idx     <= '0;
            tx_q        <= 1'b1;
        end else begin
            if (i_tick) begin
                tick_cnt <= tick_cnt + 4'd1;
            end
            case (state)
                TX_IDLE: begin
                    // Start bit is aligned to the next tick.
                    if (accept) begin
                        pending <= 1'b1;
                    end else if (pending && i_tick) begin
                        state    <= TX_START;
                        pending  <= 1'b0;
                        tick_cnt <= '0;
                        tx_q     <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                        tx_q    <= data_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state       <= TX_STOP;
                            second_stop <= 1'b0;
                            tx_q        <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            tx_q    <= data_q[bit_idx + 3'd1];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        if (i_stop_bits == STOP_TWO && !second_stop) begin
                            second_stop <= 1'b1;
                        end else begin
                            state <= TX_IDLE;
                        end
                    end
                end
                default: begin
                    state <= TX_IDLE;
                    tx_q  <= 1'b1;
                end
            endcase
        end
    end

endmodule

// File: hw/uart_config_regs.sv
module uart_config_regs #(
    parameter int DIVISOR_WIDTH = 16
) (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_cfg_valid,
    input  uart_pkg::uart_cfg_t i_cfg,
    input  logic                i_tx_busy,
    input  logic                i_rx_busy,
    output logic                o_cfg_ready,
    output uart_pkg::uart_cfg_t o_cfg
);

    import uart_pkg::*;

    // Reset defaults.
    localparam divisor_t   DEFAULT_DIVISOR = divisor_t'(3);
    localparam stop_bits_t DEFAULT_STOP    = STOP_ONE;

    // Only the bits the divider counter can hold are kept.
    localparam divisor_t DIVISOR_MASK = divisor_t'({DIVISOR_WIDTH{1'b1}});

    uart_cfg_t cfg_q;
    logic      write_en;

    //////////////////////////////
    // Write port
    //////////////////////////////

    // Both engines idle, so no frame sees a rate change.
    assign o_cfg_ready = !i_tx_busy && !i_rx_busy;
    assign write_en    = i_cfg_valid && o_cfg_ready;

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            cfg_q.divisor   <= DEFAULT_DIVISOR;
            cfg_q.stop_bits <= DEFAULT_STOP;
        end else if (write_en) begin
            cfg_q.divisor   <= i_cfg.divisor & DIVISOR_MASK;
            cfg_q.stop_bits <= i_cfg.stop_bits;
        end
    end

    assign o_cfg = cfg_q;

endmodule

// File: hw/uart_baud_gen.sv
module uart_baud_gen #(
    parameter int DIVISOR_WIDTH = 16
) (
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic [DIVISOR_WIDTH-1:0] i_divisor,
    output logic                     o_tick
);

    logic [DIVISOR_WIDTH-1:0] count;
    logic [DIVISOR_WIDTH-1:0] divisor_q;

    // Counts divisor down to zero, so one tick every divisor+1 clocks.
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            count     <= '0;
            divisor_q <= '0;
        end else begin
            divisor_q <= i_divisor;
            if (i_divisor != divisor_q) begin
                // New rate, restart the period.
                count <= i_divisor;
            end else if (count == '0) begin
                count <= i_divisor;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign o_tick = (count == '0) && (i_divisor == divisor_q);

endmodule

// File: hw/uart_pkg.sv
package uart_pkg;

    //////////////////////////////
    // Widths with a meaning
    //////////////////////////////

    // One data byte of a frame.
    typedef logic [7:0] uart_byte_t;

    // Tick position inside one bit, 16 ticks per bit.
    typedef logic [3:0] tick_count_t;

    // Data bit index, LSB first.
    typedef logic [2:0] bit_index_t;

    // Full width of the divisor field.
    typedef logic [15:0] divisor_t;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    typedef enum logic {
        STOP_ONE = 1'b0,
        STOP_TWO = 1'b1
    } stop_bits_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    typedef struct packed {
        divisor_t   divisor;
        stop_bits_t stop_bits;
    } uart_cfg_t;

    typedef struct packed {
        uart_byte_t data;
        logic       frame_error;
        logic       overrun;
    } rx_status_t;

endpackage
